// ==== common/hci_ecc_consts.svh ====
// ***************************************************************************
// Fixed sizes of the ECC memory interconnect
// Widths, port and bank counts and the address fields of bank interleaving.
// Include this file wherever one of these constants is needed.
// ***************************************************************************
`ifndef HCI_ECC_CONSTS_SVH
`define HCI_ECC_CONSTS_SVH

`define HCI_N_CORE    2  // Core initiator ports
`define HCI_N_BANK    4  // Memory banks
`define HCI_ADDR_W    16 // Byte address width
`define HCI_DATA_W    32 // Word width
`define HCI_CODE_W    39 // Data, Hamming and overall parity bits
`define HCI_HAM_W     6  // Hamming check bits
`define HCI_BANK_LSB  2  // Bank select starts above the byte offset
`define HCI_BANK_W    2  // Bank select width
`define HCI_BADDR_LSB 4  // Word-in-bank address starts here
`define HCI_CNT_W     16 // Error counter width

`endif

// ==== common/hci_ecc_pkg.sv ====
// ***************************************************************************
// Shared types of the ECC memory interconnect
// Holds the address and data types, the owner and register enums and the
// SECDED functions used by the bank arbiters. Import where needed.
// ***************************************************************************
`include "hci_ecc_consts.svh"

package hci_ecc_pkg;

  typedef logic [`HCI_ADDR_W-1:0]                tcdm_addr_t; // Byte address
  typedef logic [`HCI_DATA_W-1:0]                tcdm_data_t; // One word
  typedef logic [2*`HCI_DATA_W-1:0]              hwpe_data_t; // Low word to even bank
  typedef logic [`HCI_BANK_W-1:0]                bank_sel_t;
  typedef logic [`HCI_ADDR_W-`HCI_BADDR_LSB-1:0] bank_addr_t; // Word inside a bank
  typedef logic [`HCI_CODE_W-1:0]                code_word_t;
  typedef logic [`HCI_CNT_W-1:0]                 err_count_t;

  typedef enum logic [1:0] {
    OWNER_NONE,
    OWNER_CORE,
    OWNER_HWPE
  } arb_owner_e;

  typedef enum logic {
    REG_CORR_CNT   = 1'b0,
    REG_UNCORR_CNT = 1'b1
  } wb_reg_e;

  typedef struct packed {
    tcdm_data_t data;       // Corrected word
    logic       single_err; // Corrected, data valid
    logic       double_err; // Uncorrectable
  } ecc_dec_t;

  // Hamming positions 1..38 sit at bits 0..37, powers of two hold check bits
  function automatic code_word_t ecc_encode(input tcdm_data_t data);
    code_word_t  code;
    int unsigned d;
    code = '0;
    d    = 0;
    for (int unsigned pos = 1; pos < `HCI_CODE_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin // Data slot
        code[pos-1] = data[d];
        d++;
      end
    end
    for (int unsigned p = 0; p < `HCI_HAM_W; p++) begin
      for (int unsigned pos = 1; pos < `HCI_CODE_W; pos++) begin
        if (((pos >> p) & 1) == 1 && pos != (1 << p)) begin
          code[(1<<p)-1] ^= code[pos-1];
        end
      end
    end
    code[`HCI_CODE_W-1] = ^code[`HCI_CODE_W-2:0]; // Overall parity
    return code;
  endfunction

  function automatic ecc_dec_t ecc_decode(input code_word_t code);
    ecc_dec_t              res;
    logic [`HCI_HAM_W-1:0] syn;
    logic                  par;
    code_word_t            fix;
    int unsigned           d;
    syn = '0;
    for (int unsigned p = 0; p < `HCI_HAM_W; p++) begin
      for (int unsigned pos = 1; pos < `HCI_CODE_W; pos++) begin
        if (((pos >> p) & 1) == 1) begin
          syn[p] ^= code[pos-1];
        end
      end
    end
    par = ^code; // Odd weight means an odd number of flips
    fix = code;
    if (par && syn != 0 && syn < `HCI_CODE_W) begin
      fix[syn-1] = ~fix[syn-1]; // Syndrome points at the flipped bit
    end
    res.single_err = par && syn < `HCI_CODE_W;
    res.double_err = (!par && syn != 0) || (par && syn >= `HCI_CODE_W);
    res.data       = '0;
    d              = 0;
    for (int unsigned pos = 1; pos < `HCI_CODE_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        res.data[d] = fix[pos-1];
        d++;
      end
    end
    return res;
  endfunction

endpackage

// ==== common/tcdm_bank_if.sv ====
// ***************************************************************************
// Word-wide request and response channel between one branch and one bank
// arbiter. Grant is combinational, r_valid follows each accepted request
// by exactly one cycle, for reads and writes alike.
// ***************************************************************************
`timescale 1ns/10ps

interface tcdm_bank_if;
  import hci_ecc_pkg::*;

  logic       req;
  logic       wen;     // 1 means read
  bank_addr_t add;     // Word inside the bank
  tcdm_data_t wdata;
  logic       gnt;
  logic       r_valid;
  tcdm_data_t r_data;  // Already corrected

  modport initiator (output req, wen, add, wdata, input gnt, r_valid, r_data);
  modport target    (input req, wen, add, wdata, output gnt, r_valid, r_data);

endinterface

// ==== core_branch/core_xbar.sv ====
// ***************************************************************************
// Word-interleaved crossbar of the core branch
// Routes two core ports to the four banks with a round-robin choice per
// bank and steers each response back to the core that owns it.
// ***************************************************************************
`timescale 1ns/10ps
`include "hci_ecc_consts.svh"

module core_xbar (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic [`HCI_N_CORE-1:0]                  core_req_i,
  input  logic [`HCI_N_CORE-1:0]                  core_wen_i,
  input  hci_ecc_pkg::tcdm_addr_t [`HCI_N_CORE-1:0] core_add_i,
  input  hci_ecc_pkg::tcdm_data_t [`HCI_N_CORE-1:0] core_wdata_i,
  output logic [`HCI_N_CORE-1:0]                  core_gnt_o,
  output logic [`HCI_N_CORE-1:0]                  core_r_valid_o,
  output hci_ecc_pkg::tcdm_data_t [`HCI_N_CORE-1:0] core_r_data_o,
  tcdm_bank_if.initiator                          bank_mp [`HCI_N_BANK]
);
  import hci_ecc_pkg::*;

  logic [`HCI_N_BANK-1:0][`HCI_N_CORE-1:0] hit; // Core c addresses bank b
  logic [`HCI_N_BANK-1:0]                  b_sel; // Core chosen per bank
  logic [`HCI_N_BANK-1:0]                  b_gnt;
  logic [`HCI_N_BANK-1:0]                  b_own; // Core owning the response
  logic [`HCI_N_BANK-1:0]                  b_rvalid;
  tcdm_data_t [`HCI_N_BANK-1:0]            b_rdata;

  for (genvar b = 0; b < `HCI_N_BANK; b++) begin : gen_bank
    logic rr_q;  // Core favored on contention
    logic own_q;

    for (genvar c = 0; c < `HCI_N_CORE; c++) begin : gen_hit
      assign hit[b][c] = core_req_i[c] &&
                         (core_add_i[c][`HCI_BANK_LSB +: `HCI_BANK_W] == bank_sel_t'(b));
    end

    assign b_sel[b] = (&hit[b]) ? rr_q : hit[b][1]; // Two-way pick
    assign bank_mp[b].req   = |hit[b];
    assign bank_mp[b].wen   = core_wen_i[b_sel[b]];
    assign bank_mp[b].add   = core_add_i[b_sel[b]][`HCI_ADDR_W-1:`HCI_BADDR_LSB];
    assign bank_mp[b].wdata = core_wdata_i[b_sel[b]];
    assign b_gnt[b]    = bank_mp[b].gnt;
    assign b_rvalid[b] = bank_mp[b].r_valid;
    assign b_rdata[b]  = bank_mp[b].r_data;
    assign b_own[b]    = own_q;

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        rr_q  <= 1'b0; // Core 0 first
        own_q <= 1'b0;
      end else if (bank_mp[b].req && bank_mp[b].gnt) begin
        own_q <= b_sel[b];
        if (&hit[b]) begin
          rr_q <= ~b_sel[b]; // Loser wins next time
        end
      end
    end
  end

  always_comb begin
    core_gnt_o     = '0;
    core_r_valid_o = '0;
    core_r_data_o  = '0;
    for (int b = 0; b < `HCI_N_BANK; b++) begin
      for (int c = 0; c < `HCI_N_CORE; c++) begin
        if (hit[b][c] && b_gnt[b] && b_sel[b] == c) begin
          core_gnt_o[c] = 1'b1;
        end
      end
      if (b_rvalid[b]) begin
        core_r_valid_o[b_own[b]] = 1'b1;
        core_r_data_o[b_own[b]]  = b_rdata[b];
      end
    end
  end

endmodule

// ==== hwpe_branch/hwpe_splitter.sv ====
// ***************************************************************************
// Splitter of the accelerator branch
// Turns a 64-bit HWPE access into two word accesses on an adjacent bank
// pair, granted only when both banks are free, and merges the responses.
// ***************************************************************************
`timescale 1ns/10ps
`include "hci_ecc_consts.svh"

module hwpe_splitter (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    hwpe_req_i,
  input  logic                    hwpe_wen_i,
  input  hci_ecc_pkg::tcdm_addr_t hwpe_add_i,
  input  hci_ecc_pkg::hwpe_data_t hwpe_wdata_i,
  output logic                    hwpe_gnt_o,
  output logic                    hwpe_r_valid_o,
  output hci_ecc_pkg::hwpe_data_t hwpe_r_data_o,
  tcdm_bank_if.initiator          bank_mp [`HCI_N_BANK]
);
  import hci_ecc_pkg::*;

  logic                         pair;   // Addressed bank pair
  logic                         pair_q; // Pair of the access in flight
  bank_sel_t                    even_b, odd_b, even_q, odd_q;
  logic                         both_free;
  logic [`HCI_N_BANK-1:0]       b_gnt;
  logic [`HCI_N_BANK-1:0]       b_rvalid;
  tcdm_data_t [`HCI_N_BANK-1:0] b_rdata;

  assign pair      = hwpe_add_i[`HCI_BANK_LSB+1];
  assign even_b    = {pair, 1'b0};
  assign odd_b     = {pair, 1'b1};
  assign even_q    = {pair_q, 1'b0};
  assign odd_q     = {pair_q, 1'b1};
  assign both_free = b_gnt[even_b] && b_gnt[odd_b]; // No core on the pair
  assign hwpe_gnt_o = hwpe_req_i && both_free;

  for (genvar b = 0; b < `HCI_N_BANK; b++) begin : gen_bank
    // Requests stay low unless both halves go in together
    assign bank_mp[b].req   = hwpe_gnt_o && ((b >> 1) == pair);
    assign bank_mp[b].wen   = hwpe_wen_i;
    assign bank_mp[b].add   = hwpe_add_i[`HCI_ADDR_W-1:`HCI_BADDR_LSB];
    assign bank_mp[b].wdata = hwpe_wdata_i[(b % 2)*`HCI_DATA_W +: `HCI_DATA_W];
    assign b_gnt[b]    = bank_mp[b].gnt;
    assign b_rvalid[b] = bank_mp[b].r_valid;
    assign b_rdata[b]  = bank_mp[b].r_data;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pair_q <= 1'b0;
    end else if (hwpe_gnt_o) begin
      pair_q <= pair;
    end
  end

  assign hwpe_r_valid_o = b_rvalid[even_q] && b_rvalid[odd_q]; // Both halves back
  assign hwpe_r_data_o  = {b_rdata[odd_q], b_rdata[even_q]};

endmodule

// ==== source/bank_arbiter.sv ====
// ***************************************************************************
// Per-bank arbiter between the core and the HWPE branch
// Cores always win. Write data is SECDED encoded on the way in, read data
// decoded and corrected on the way out, with one error pulse per read.
// ***************************************************************************
`timescale 1ns/10ps

module bank_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  hci_ecc_pkg::code_word_t bank_rdata_i,
  tcdm_bank_if.target             core_mp,
  tcdm_bank_if.target             hwpe_mp,
  output logic                    bank_req_o,
  output logic                    bank_we_o,
  output hci_ecc_pkg::bank_addr_t bank_add_o,
  output hci_ecc_pkg::code_word_t bank_wdata_o,
  output logic                    corr_err_o,
  output logic                    uncorr_err_o
);
  import hci_ecc_pkg::*;

  logic       core_acc; // Core access this cycle
  logic       hwpe_acc;
  logic       rd_q;     // Access in flight is a read
  arb_owner_e owner_q;
  ecc_dec_t   dec;

  assign core_mp.gnt = core_mp.req;
  assign hwpe_mp.gnt = !core_mp.req; // Free bank only
  assign core_acc    = core_mp.req;
  assign hwpe_acc    = hwpe_mp.req && !core_mp.req;

  assign bank_req_o   = core_acc || hwpe_acc;
  assign bank_we_o    = bank_req_o && (core_acc ? !core_mp.wen : !hwpe_mp.wen);
  assign bank_add_o   = core_acc ? core_mp.add : hwpe_mp.add;
  assign bank_wdata_o = ecc_encode(core_acc ? core_mp.wdata : hwpe_mp.wdata);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      owner_q <= OWNER_NONE;
      rd_q    <= 1'b0;
    end else begin
      owner_q <= core_acc ? OWNER_CORE : (hwpe_acc ? OWNER_HWPE : OWNER_NONE);
      rd_q    <= bank_req_o && !bank_we_o;
    end
  end

  assign dec = ecc_decode(bank_rdata_i); // Bank answers one cycle late

  assign core_mp.r_valid = (owner_q == OWNER_CORE);
  assign hwpe_mp.r_valid = (owner_q == OWNER_HWPE);
  assign core_mp.r_data  = dec.data;
  assign hwpe_mp.r_data  = dec.data;

  assign corr_err_o   = rd_q && dec.single_err; // Writes return no codeword
  assign uncorr_err_o = rd_q && dec.double_err;

endmodule

// ==== source/ecc_err_manager.sv ====
// ***************************************************************************
// ECC error counters with a Wishbone classic slave port
// Word 0 counts corrected reads, word 1 uncorrectable ones. Any write to a
// counter clears it. Each access is acked one cycle after it is seen.
// ***************************************************************************
`timescale 1ns/10ps
`include "hci_ecc_consts.svh"

module ecc_err_manager (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [`HCI_N_BANK-1:0] corr_err_i,
  input  logic [`HCI_N_BANK-1:0] uncorr_err_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [`HCI_ADDR_W-1:0] wb_adr_i,
  input  logic [`HCI_DATA_W-1:0] wb_dat_i,
  output logic [`HCI_DATA_W-1:0] wb_dat_o,
  output logic                   wb_ack_o
);
  import hci_ecc_pkg::*;

  err_count_t corr_q;
  err_count_t uncorr_q;
  logic       wb_req;  // New access, not yet acked
  logic       idx_ok;  // Address hits the register window
  wb_reg_e    reg_sel;
  logic       clr_corr;
  logic       clr_uncorr;

  function automatic err_count_t sat_add(input err_count_t cnt,
                                         input logic [`HCI_N_BANK-1:0] pulses);
    logic [`HCI_CNT_W:0] sum;
    sum = {1'b0, cnt};
    for (int b = 0; b < `HCI_N_BANK; b++) begin
      sum += pulses[b];
    end
    return sum[`HCI_CNT_W] ? '1 : sum[`HCI_CNT_W-1:0]; // Stick at max
  endfunction

  assign wb_req     = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign idx_ok     = (wb_adr_i[`HCI_ADDR_W-1:`HCI_BANK_LSB+1] == '0);
  assign reg_sel    = wb_reg_e'(wb_adr_i[`HCI_BANK_LSB]); // Word index
  assign clr_corr   = wb_req && wb_we_i && idx_ok && (reg_sel == REG_CORR_CNT);
  assign clr_uncorr = wb_req && wb_we_i && idx_ok && (reg_sel == REG_UNCORR_CNT);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      corr_q   <= '0;
      uncorr_q <= '0;
      wb_ack_o <= 1'b0;
    end else begin
      corr_q   <= clr_corr ? '0 : sat_add(corr_q, corr_err_i);
      uncorr_q <= clr_uncorr ? '0 : sat_add(uncorr_q, uncorr_err_i);
      wb_ack_o <= wb_req;
    end
  end

  // Write data carries no meaning, only the address selects the clear
  always_ff @(posedge clk_i) begin
    if (wb_req) begin
      if (!idx_ok || wb_we_i) begin
        wb_dat_o <= '0;
      end else begin
        wb_dat_o <= (reg_sel == REG_CORR_CNT) ? `HCI_DATA_W'(corr_q) : `HCI_DATA_W'(uncorr_q);
      end
    end
  end

endmodule

// ==== source/hci_ecc_interconnect.sv ====
// ***************************************************************************
// Top level of the ECC-protected cluster memory interconnect
// Two core ports and one 64-bit HWPE port share four SECDED protected
// banks. Banks sit outside at plain ports, error counts are read over
// Wishbone.
// ***************************************************************************
`timescale 1ns/10ps
`include "hci_ecc_consts.svh"

module hci_ecc_interconnect (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // Core ports
  input  logic [`HCI_N_CORE-1:0]                  core_req_i,
  input  logic [`HCI_N_CORE-1:0]                  core_wen_i,
  input  hci_ecc_pkg::tcdm_addr_t [`HCI_N_CORE-1:0] core_add_i,
  input  hci_ecc_pkg::tcdm_data_t [`HCI_N_CORE-1:0] core_wdata_i,
  output logic [`HCI_N_CORE-1:0]                  core_gnt_o,
  output logic [`HCI_N_CORE-1:0]                  core_r_valid_o,
  output hci_ecc_pkg::tcdm_data_t [`HCI_N_CORE-1:0] core_r_data_o,
  // HWPE port, 8-byte aligned
  input  logic                                    hwpe_req_i,
  input  logic                                    hwpe_wen_i,
  input  hci_ecc_pkg::tcdm_addr_t                 hwpe_add_i,
  input  hci_ecc_pkg::hwpe_data_t                 hwpe_wdata_i,
  output logic                                    hwpe_gnt_o,
  output logic                                    hwpe_r_valid_o,
  output hci_ecc_pkg::hwpe_data_t                 hwpe_r_data_o,
  // Banks
  output logic [`HCI_N_BANK-1:0]                  bank_req_o,
  output logic [`HCI_N_BANK-1:0]                  bank_we_o,
  output hci_ecc_pkg::bank_addr_t [`HCI_N_BANK-1:0] bank_add_o,
  output hci_ecc_pkg::code_word_t [`HCI_N_BANK-1:0] bank_wdata_o,
  input  hci_ecc_pkg::code_word_t [`HCI_N_BANK-1:0] bank_rdata_i,
  // Wishbone classic slave
  input  logic                                    wb_cyc_i,
  input  logic                                    wb_stb_i,
  input  logic                                    wb_we_i,
  input  logic [`HCI_ADDR_W-1:0]                  wb_adr_i,
  input  logic [`HCI_DATA_W-1:0]                  wb_dat_i,
  output logic [`HCI_DATA_W-1:0]                  wb_dat_o,
  output logic                                    wb_ack_o
);

  logic [`HCI_N_BANK-1:0] corr_err;   // Per-bank read error pulses
  logic [`HCI_N_BANK-1:0] uncorr_err;

  tcdm_bank_if core_bus [`HCI_N_BANK] (); // Core branch to arbiters
  tcdm_bank_if hwpe_bus [`HCI_N_BANK] (); // HWPE branch to arbiters

  core_xbar u_core_xbar (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .core_req_i     ( core_req_i     ),
    .core_wen_i     ( core_wen_i     ),
    .core_add_i     ( core_add_i     ),
    .core_wdata_i   ( core_wdata_i   ),
    .core_gnt_o     ( core_gnt_o     ),
    .core_r_valid_o ( core_r_valid_o ),
    .core_r_data_o  ( core_r_data_o  ),
    .bank_mp        ( core_bus       )
  );

  hwpe_splitter u_hwpe_splitter (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .hwpe_req_i     ( hwpe_req_i     ),
    .hwpe_wen_i     ( hwpe_wen_i     ),
    .hwpe_add_i     ( hwpe_add_i     ),
    .hwpe_wdata_i   ( hwpe_wdata_i   ),
    .hwpe_gnt_o     ( hwpe_gnt_o     ),
    .hwpe_r_valid_o ( hwpe_r_valid_o ),
    .hwpe_r_data_o  ( hwpe_r_data_o  ),
    .bank_mp        ( hwpe_bus       )
  );

  for (genvar b = 0; b < `HCI_N_BANK; b++) begin : gen_arb
    bank_arbiter u_bank_arbiter (
      .clk_i        ( clk_i           ),
      .rst_n_i      ( rst_n_i         ),
      .bank_rdata_i ( bank_rdata_i[b] ),
      .core_mp      ( core_bus[b]     ),
      .hwpe_mp      ( hwpe_bus[b]     ),
      .bank_req_o   ( bank_req_o[b]   ),
      .bank_we_o    ( bank_we_o[b]    ),
      .bank_add_o   ( bank_add_o[b]   ),
      .bank_wdata_o ( bank_wdata_o[b] ),
      .corr_err_o   ( corr_err[b]     ),
      .uncorr_err_o ( uncorr_err[b]   )
    );
  end

  ecc_err_manager u_ecc_err_manager (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .corr_err_i   ( corr_err   ),
    .uncorr_err_i ( uncorr_err ),
    .wb_cyc_i     ( wb_cyc_i   ),
    .wb_stb_i     ( wb_stb_i   ),
    .wb_we_i      ( wb_we_i    ),
    .wb_adr_i     ( wb_adr_i   ),
    .wb_dat_i     ( wb_dat_i   ),
    .wb_dat_o     ( wb_dat_o   ),
    .wb_ack_o     ( wb_ack_o   )
  );

endmodule

// ==== tb/hci_ecc_interconnect_checker.sv ====
// ***************************************************************************
// Concurrent assertions on the top-level handshakes of the interconnect
// Bound to every instance of the top level. Covers core response timing,
// HWPE exclusion on its bank pair and the single-cycle Wishbone ack.
// ***************************************************************************
`timescale 1ns/10ps
`include "hci_ecc_consts.svh"

module hci_ecc_interconnect_checker (
  input logic                                    clk_i,
  input logic                                    rst_n_i,
  input hci_ecc_pkg::tcdm_addr_t [`HCI_N_CORE-1:0] core_add_i,
  input logic [`HCI_N_CORE-1:0]                  core_gnt_o,
  input logic [`HCI_N_CORE-1:0]                  core_r_valid_o,
  input hci_ecc_pkg::tcdm_addr_t                 hwpe_add_i,
  input logic                                    hwpe_gnt_o,
  input logic                                    wb_ack_o
);

  logic [`HCI_N_CORE-1:0] pair_gnt;     // Core granted on the HWPE pair
  int                     failures = 0; // Failed assertions so far

  for (genvar c = 0; c < `HCI_N_CORE; c++) begin : gen_core
    assign pair_gnt[c] = core_gnt_o[c] &&
                         (core_add_i[c][`HCI_BANK_LSB+1] == hwpe_add_i[`HCI_BANK_LSB+1]);

    // Response exactly one cycle after the grant
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     core_gnt_o[c] |=> core_r_valid_o[c])
      else begin
        $error("core %0d grant not followed by r_valid", c);
        failures++;
      end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   hwpe_gnt_o |-> pair_gnt == '0) // Cores own the pair first
    else begin
      $error("HWPE granted while a core was granted on its bank pair");
      failures++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   $rose(wb_ack_o) |=> !wb_ack_o) // Single-cycle ack
    else begin
      $error("wb_ack_o held high for more than one cycle");
      failures++;
    end

endmodule

bind hci_ecc_interconnect hci_ecc_interconnect_checker u_hci_ecc_interconnect_checker (.*);

// ==== tb/hci_ecc_interconnect_tb.sv ====
// ***************************************************************************
// Testbench of the ECC memory interconnect
// Models the four banks as codeword arrays with error injection, applies a
// table of core, HWPE and Wishbone operations and checks data and counts.
// ***************************************************************************
`timescale 1ns/10ps
`include "hci_ecc_consts.svh"

module hci_ecc_interconnect_tb;
  import hci_ecc_pkg::*;

  localparam int TIMEOUT   = 20; // Cycles per wait
  localparam int INIT_HWPE = 2;  // Initiator index of the HWPE

  typedef enum {OP_WRITE, OP_READ, OP_COUNT, OP_CLEAR, OP_CONTEND} op_e;

  typedef struct {
    op_e        op;
    int         init;       // Core index or INIT_HWPE
    tcdm_addr_t addr;       // Byte address, register index for OP_CLEAR
    hwpe_data_t wdata;
    code_word_t flip;       // XORed into the stored codeword before a read
    bit         chk;        // Compare read data
    hwpe_data_t exp;
    err_count_t exp_corr;
    err_count_t exp_uncorr;
  } row_t;

  logic                             clk_i;
  logic                             rst_n_i;
  logic [`HCI_N_CORE-1:0]           core_req_i;
  logic [`HCI_N_CORE-1:0]           core_wen_i;
  tcdm_addr_t [`HCI_N_CORE-1:0]     core_add_i;
  tcdm_data_t [`HCI_N_CORE-1:0]     core_wdata_i;
  logic [`HCI_N_CORE-1:0]           core_gnt_o;
  logic [`HCI_N_CORE-1:0]           core_r_valid_o;
  tcdm_data_t [`HCI_N_CORE-1:0]     core_r_data_o;
  logic                             hwpe_req_i;
  logic                             hwpe_wen_i;
  tcdm_addr_t                       hwpe_add_i;
  hwpe_data_t                       hwpe_wdata_i;
  logic                             hwpe_gnt_o;
  logic                             hwpe_r_valid_o;
  hwpe_data_t                       hwpe_r_data_o;
  logic [`HCI_N_BANK-1:0]           bank_req_o;
  logic [`HCI_N_BANK-1:0]           bank_we_o;
  bank_addr_t [`HCI_N_BANK-1:0]     bank_add_o;
  code_word_t [`HCI_N_BANK-1:0]     bank_wdata_o;
  code_word_t [`HCI_N_BANK-1:0]     bank_rdata_i;
  logic                             wb_cyc_i;
  logic                             wb_stb_i;
  logic                             wb_we_i;
  logic [`HCI_ADDR_W-1:0]           wb_adr_i;
  logic [`HCI_DATA_W-1:0]           wb_dat_i;
  logic [`HCI_DATA_W-1:0]           wb_dat_o;
  logic                             wb_ack_o;

  code_word_t bank_mem [`HCI_N_BANK][2**(`HCI_ADDR_W-`HCI_BADDR_LSB)]; // Bank contents
  row_t       rows[$];
  bit         test_ok;  // Current row still clean
  int         n_fail;
  int         n_asrt;

  hci_ecc_interconnect u_hci_ecc_interconnect (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i; // 40 ns period
  end

  // Banks never stall, read data one cycle after the request
  always @(posedge clk_i) begin
    for (int b = 0; b < `HCI_N_BANK; b++) begin
      if (bank_req_o[b] && bank_we_o[b]) begin
        bank_mem[b][bank_add_o[b]] <= bank_wdata_o[b];
      end else if (bank_req_o[b]) begin
        bank_rdata_i[b] <= bank_mem[b][bank_add_o[b]];
      end
    end
  end

  task automatic check_word(input string name, input tcdm_data_t got, input tcdm_data_t exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_wide(input string name, input hwpe_data_t got, input hwpe_data_t exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_count(input string name, input err_count_t got, input err_count_t exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      test_ok = 1'b0;
    end
  endtask

  task automatic core_access(input int c, input logic rd, input tcdm_addr_t addr,
                             input tcdm_data_t wdata, output tcdm_data_t rdata);
    int n;
    bit granted;
    n     = 0;
    rdata = '0;
    @(posedge clk_i);
    core_req_i[c]   <= 1'b1;
    core_wen_i[c]   <= rd;
    core_add_i[c]   <= addr;
    core_wdata_i[c] <= wdata;
    @(negedge clk_i);
    while (!core_gnt_o[c] && n < TIMEOUT) begin // Held until granted
      n++;
      @(negedge clk_i);
    end
    granted = core_gnt_o[c];
    if (!granted) begin
      $display("core %0d request to 0x%h was never granted", c, addr);
      test_ok = 1'b0;
    end
    @(posedge clk_i);
    core_req_i[c] <= 1'b0;
    if (granted) begin
      @(negedge clk_i);
      if (!core_r_valid_o[c]) begin
        $display("core %0d got no r_valid one cycle after its grant", c);
        test_ok = 1'b0;
      end
      rdata = core_r_data_o[c];
    end
  endtask

  task automatic hwpe_access(input logic rd, input tcdm_addr_t addr,
                             input hwpe_data_t wdata, output hwpe_data_t rdata);
    int n;
    bit granted;
    n     = 0;
    rdata = '0;
    @(posedge clk_i);
    hwpe_req_i   <= 1'b1;
    hwpe_wen_i   <= rd;
    hwpe_add_i   <= addr;
    hwpe_wdata_i <= wdata;
    @(negedge clk_i);
    while (!hwpe_gnt_o && n < TIMEOUT) begin // Waits out core traffic
      n++;
      @(negedge clk_i);
    end
    granted = hwpe_gnt_o;
    if (!granted) begin
      $display("HWPE request to 0x%h was never granted", addr);
      test_ok = 1'b0;
    end
    @(posedge clk_i);
    hwpe_req_i <= 1'b0;
    if (granted) begin
      @(negedge clk_i);
      if (!hwpe_r_valid_o) begin
        $display("HWPE got no r_valid one cycle after its grant");
        test_ok = 1'b0;
      end
      rdata = hwpe_r_data_o;
    end
  endtask

  task automatic wb_access(input logic we, input wb_reg_e idx,
                           output logic [`HCI_DATA_W-1:0] data);
    int n;
    n = 0;
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= `HCI_ADDR_W'(idx) << `HCI_BANK_LSB; // Word index to byte address
    wb_dat_i <= $urandom;                           // Ignored by a clear
    @(negedge clk_i);
    while (!wb_ack_o && n < TIMEOUT) begin
      n++;
      @(negedge clk_i);
    end
    if (!wb_ack_o) begin
      $display("Wishbone access to register %0d was never acknowledged", idx);
      test_ok = 1'b0;
    end
    data = wb_dat_o;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic add_row(input op_e op, input int init, input tcdm_addr_t addr,
                         input hwpe_data_t wdata, input code_word_t flip, input bit chk,
                         input hwpe_data_t exp, input err_count_t corr, input err_count_t uncorr);
    rows.push_back('{op, init, addr, wdata, flip, chk, exp, corr, uncorr});
  endtask

  task automatic build_table();
    tcdm_addr_t a;
    tcdm_data_t d;
    hwpe_data_t w0;
    hwpe_data_t w1;
    for (int c = 0; c < `HCI_N_CORE; c++) begin
      for (int b = 0; b < `HCI_N_BANK; b++) begin
        a = 16'h0800 + c * 16'h0100 + b * 4; // One word in every bank
        d = $urandom;
        add_row(OP_WRITE, c, a, d, '0, 1'b0, '0, 0, 0);
        add_row(OP_READ, c, a, '0, '0, 1'b1, d, 0, 0);
      end
    end
    w0 = {$urandom, $urandom};
    w1 = {$urandom, $urandom};
    add_row(OP_WRITE, INIT_HWPE, 16'h0100, w0, '0, 1'b0, '0, 0, 0); // Banks 0 and 1
    add_row(OP_READ, 0, 16'h0100, '0, '0, 1'b1, w0[31:0], 0, 0);     // Low word, even bank
    add_row(OP_READ, 1, 16'h0104, '0, '0, 1'b1, w0[63:32], 0, 0);
    add_row(OP_READ, INIT_HWPE, 16'h0100, '0, '0, 1'b1, w0, 0, 0);
    add_row(OP_WRITE, INIT_HWPE, 16'h0308, w1, '0, 1'b0, '0, 0, 0); // Banks 2 and 3
    add_row(OP_READ, 0, 16'h0308, '0, '0, 1'b1, w1[31:0], 0, 0);
    add_row(OP_READ, 1, 16'h030c, '0, '0, 1'b1, w1[63:32], 0, 0);
    add_row(OP_READ, INIT_HWPE, 16'h0308, '0, '0, 1'b1, w1, 0, 0);
    add_row(OP_COUNT, 0, '0, '0, '0, 1'b0, '0, 0, 0);
    d = $urandom;
    add_row(OP_WRITE, 0, 16'h0400, d, '0, 1'b0, '0, 0, 0);
    add_row(OP_READ, 0, 16'h0400, '0, 39'h1 << 20, 1'b1, d, 0, 0); // Single flip
    add_row(OP_COUNT, 0, '0, '0, '0, 1'b0, '0, 1, 0);
    d = $urandom;
    add_row(OP_WRITE, 1, 16'h0504, d, '0, 1'b0, '0, 0, 0);
    add_row(OP_READ, 1, 16'h0504, '0, 39'h408, 1'b0, '0, 0, 0); // Bits 3 and 10
    add_row(OP_COUNT, 0, '0, '0, '0, 1'b0, '0, 1, 1);
    add_row(OP_CONTEND, 0, 16'h0100, '0, '0, 1'b1, w0, 0, 0);
    add_row(OP_COUNT, 0, '0, '0, '0, 1'b0, '0, 1, 1);
    add_row(OP_CLEAR, 0, tcdm_addr_t'(REG_CORR_CNT), '0, '0, 1'b0, '0, 0, 0);
    add_row(OP_COUNT, 0, '0, '0, '0, 1'b0, '0, 0, 1);
    add_row(OP_CLEAR, 0, tcdm_addr_t'(REG_UNCORR_CNT), '0, '0, 1'b0, '0, 0, 0);
    add_row(OP_COUNT, 0, '0, '0, '0, 1'b0, '0, 0, 0);
  endtask

  task automatic run_row(input row_t r);
    tcdm_data_t             r0;
    tcdm_data_t             r1;
    hwpe_data_t             rw;
    logic [`HCI_DATA_W-1:0] reg_val;
    bit                     rd;
    rd = (r.op == OP_READ);
    case (r.op)
      OP_WRITE, OP_READ: begin
        if (rd) begin // Error injection in the stored codeword
          bank_mem[r.addr[`HCI_BANK_LSB +: `HCI_BANK_W]][r.addr[`HCI_ADDR_W-1:`HCI_BADDR_LSB]] ^=
            r.flip;
        end
        if (r.init == INIT_HWPE) begin
          hwpe_access(rd, r.addr, r.wdata, rw);
          if (rd && r.chk) check_wide("hwpe_r_data_o", rw, r.exp);
        end else begin
          core_access(r.init, rd, r.addr, r.wdata[`HCI_DATA_W-1:0], r0);
          if (rd && r.chk) begin
            check_word($sformatf("core_r_data_o[%0d]", r.init), r0, r.exp[`HCI_DATA_W-1:0]);
          end
        end
      end
      OP_COUNT: begin
        wb_access(1'b0, REG_CORR_CNT, reg_val);
        check_count("wb_dat_o corr count", err_count_t'(reg_val), r.exp_corr);
        wb_access(1'b0, REG_UNCORR_CNT, reg_val);
        check_count("wb_dat_o uncorr count", err_count_t'(reg_val), r.exp_uncorr);
      end
      OP_CLEAR: begin
        wb_access(1'b1, wb_reg_e'(r.addr[0]), reg_val);
      end
      OP_CONTEND: begin
        fork // All three start on the same edge
          core_access(0, 1'b1, r.addr, '0, r0);
          core_access(1, 1'b1, r.addr, '0, r1);
          hwpe_access(1'b1, r.addr, '0, rw);
        join
        check_word("core_r_data_o[0]", r0, r.exp[`HCI_DATA_W-1:0]);
        check_word("core_r_data_o[1]", r1, r.exp[`HCI_DATA_W-1:0]);
        check_wide("hwpe_r_data_o", rw, r.exp);
      end
      default: ;
    endcase
  endtask

  initial begin
    void'($urandom(32'hd23c_2de1));
    rst_n_i      = 1'b0;
    core_req_i   = '0;
    core_wen_i   = '0;
    core_add_i   = '0;
    core_wdata_i = '0;
    hwpe_req_i   = 1'b0;
    hwpe_wen_i   = 1'b0;
    hwpe_add_i   = '0;
    hwpe_wdata_i = '0;
    bank_rdata_i = '0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    n_fail       = 0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    build_table();
    foreach (rows[i]) begin
      test_ok = 1'b1;
      run_row(rows[i]);
      if (!test_ok) n_fail++;
      $display("test %0d %s %s", i, rows[i].op.name(), test_ok ? "ok" : "FAIL");
    end
    n_asrt = u_hci_ecc_interconnect.u_hci_ecc_interconnect_checker.failures;
    $display("%0d tests, %0d failed, %0d assertion failures", rows.size(), n_fail, n_asrt);
    if (n_fail == 0 && n_asrt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== hci_ecc_interconnect.f ====
+incdir+common
common/hci_ecc_pkg.sv
common/tcdm_bank_if.sv
core_branch/core_xbar.sv
hwpe_branch/hwpe_splitter.sv
source/bank_arbiter.sv
source/ecc_err_manager.sv
source/hci_ecc_interconnect.sv
tb/hci_ecc_interconnect_checker.sv
tb/hci_ecc_interconnect_tb.sv
